// File: Makefile
TOP = alpha_control_tb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f alpha_control.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f alpha_control.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: alpha_control.f
design/alpha_pkg.sv
design/button_pickoff.sv
design/slot_timer.sv
design/startup_sequencer.sv
design/serial_loader.sv
design/alpha_control_top.sv
sim/alpha_control_tb.sv

// File: design/alpha_control_top.sv
`timescale 1ns/1ps

// start-up controller for the chip-under-test carrier board
module alpha_control_top (
	input logic clock,
	input logic reset,
	input logic [alpha_pkg::BUTTON_COUNT-1:0] button, // 0 power-up, 1 serial load
	output logic dreset,
	output logic sync,
	output logic tok_a_f2t,
	output logic trig_top,
	output logic sin,
	output logic sclk
);

	logic [alpha_pkg::BUTTON_COUNT-1:0] start_pulse; // one per button
	logic loader_sclk; // strobe before the dreset gating

	// identical edge detector per button
	genvar i;
	generate
		for (i = 0; i < alpha_pkg::BUTTON_COUNT; i++) begin : g_pickoff
			button_pickoff pickoff_i (
				.clock(clock),
				.reset(reset),
				.button(button[i]),
				.start_pulse(start_pulse[i])
			);
		end
	endgenerate

	// button 0 starts the power-up pulses
	startup_sequencer startup_i (
		.clock(clock),
		.reset(reset),
		.start_pulse(start_pulse[0]),
		.dreset(dreset),
		.sync(sync),
		.tok_a_f2t(tok_a_f2t),
		.trig_top(trig_top)
	);

	// button 1 starts the configuration load
	serial_loader loader_i (
		.clock(clock),
		.reset(reset),
		.start_pulse(start_pulse[1]),
		.sin(sin),
		.sclk(loader_sclk)
	);

	assign sclk = loader_sclk | dreset; // board ties the strobe high during dreset

endmodule

// File: design/alpha_pkg.sv
// shared constants and state types for the carrier board start-up controller
package alpha_pkg;

	localparam int SLOT_CYCLES = 100; // clocks per sequence slot
	localparam int PICKOFF_DEPTH = 7; // button sample pipeline length
	localparam int BUTTON_COUNT = 2; // power-up button and load button

	// quiet slots from trig_top falling to the second token
	localparam int TRIGGER_GAP_SLOTS = 1121;

	localparam int LOAD_WORD_WIDTH = 16; // power of two, index wraps on low bits
	localparam logic [LOAD_WORD_WIDTH-1:0] LOAD_WORD = 16'hf0a5; // sent lsb first
	localparam int LOAD_BITS = 20; // 16 real bits plus 4 dummy repeats

	// power-up phases, one slot each except the gap
	typedef enum logic [3:0] {
		su_idle,
		su_settle, // outputs low for one slot
		su_dreset_high,
		su_dreset_low,
		su_sync_high,
		su_sync_low,
		su_token_high,
		su_token_low,
		su_trig_high,
		su_trig_gap, // long quiet stretch
		su_token2_high,
		su_token2_low
	} startup_state_t;

	// serial load phases, three slots per bit after settle
	typedef enum logic [2:0] {
		ld_idle,
		ld_settle,
		ld_data_setup, // sin changes here
		ld_clock_high,
		ld_clock_low
	} loader_state_t;

endpackage

// File: design/button_pickoff.sv
`timescale 1ns/1ps

// one push button: sample pipeline, then a single-cycle pulse on a rising step
module button_pickoff (
	input logic clock,
	input logic reset,
	input logic button,
	output logic start_pulse
);

	logic [alpha_pkg::PICKOFF_DEPTH-1:0] samples; // [0] is the newest sample

	always_ff @(posedge clock) begin
		if (reset) begin
			samples <= '0;
			start_pulse <= 1'b0;
		end else begin
			samples <= {samples[alpha_pkg::PICKOFF_DEPTH-2:0], button}; // shift in
			// low-to-high step between the two oldest stages
			start_pulse <= (samples[alpha_pkg::PICKOFF_DEPTH-1:alpha_pkg::PICKOFF_DEPTH-2]
				== 2'b01);
		end
	end

	// a press must never produce back-to-back starts downstream
	start_pulse_single : assert property (
		@(posedge clock) disable iff (reset)
		start_pulse |=> !start_pulse
	);

endmodule

// File: design/serial_loader.sv
`timescale 1ns/1ps

// shifts the configuration word out on sin, strobed by sclk, one slot per phase
module serial_loader (
	input logic clock,
	input logic reset,
	input logic start_pulse,
	output logic sin,
	output logic sclk
);

	typedef logic [$clog2(alpha_pkg::LOAD_BITS+1)-1:0] bit_count_t;
	typedef logic [$clog2(alpha_pkg::LOAD_WORD_WIDTH)-1:0] bit_index_t;

	alpha_pkg::loader_state_t state;
	bit_count_t bit_count; // bits clocked out so far
	bit_index_t bit_index;
	logic slot_end;

	slot_timer timer_i (
		.clock(clock),
		.reset(reset),
		.restart(start_pulse),
		.slot_end(slot_end)
	);

	// count mod word width, so the dummy bits repeat bits 0 to 3
	assign bit_index = bit_count[$clog2(alpha_pkg::LOAD_WORD_WIDTH)-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= alpha_pkg::ld_idle;
			bit_count <= '0;
			sin <= 1'b0;
			sclk <= 1'b0;
		end else if (start_pulse) begin // restart the load from bit 0
			state <= alpha_pkg::ld_settle;
			bit_count <= '0;
			sin <= 1'b0;
			sclk <= 1'b0;
		end else if (slot_end) begin
			case (state)
				alpha_pkg::ld_settle: begin
					state <= alpha_pkg::ld_data_setup;
					sin <= alpha_pkg::LOAD_WORD[bit_index]; // bit 0 first
				end
				alpha_pkg::ld_data_setup: begin
					state <= alpha_pkg::ld_clock_high;
					sclk <= 1'b1;
				end
				alpha_pkg::ld_clock_high: begin
					state <= alpha_pkg::ld_clock_low;
					sclk <= 1'b0;
					bit_count <= bit_count + 1'b1; // bit taken on this falling strobe
				end
				alpha_pkg::ld_clock_low: begin
					if (bit_count == bit_count_t'(alpha_pkg::LOAD_BITS)) begin
						state <= alpha_pkg::ld_idle; // sin keeps its last value
					end else begin
						state <= alpha_pkg::ld_data_setup;
						sin <= alpha_pkg::LOAD_WORD[bit_index];
					end
				end
				default: state <= alpha_pkg::ld_idle;
			endcase
		end
	end

	// data must not move under the strobe
	sin_held_under_sclk : assert property (
		@(posedge clock) disable iff (reset)
		sclk |-> $stable(sin)
	);

endmodule

// File: design/slot_timer.sv
`timescale 1ns/1ps

// free-running slot counter, slot_end flags the last cycle of each slot
module slot_timer (
	input logic clock,
	input logic reset,
	input logic restart, // next cycle is the first of a new slot
	output logic slot_end
);

	typedef logic [$clog2(alpha_pkg::SLOT_CYCLES)-1:0] count_t;

	count_t count; // position within the slot

	always_ff @(posedge clock) begin
		if (reset || restart) begin
			count <= '0;
			slot_end <= 1'b0;
		end else begin
			if (count == count_t'(alpha_pkg::SLOT_CYCLES - 1)) begin
				count <= '0; // wrap
			end else begin
				count <= count + 1'b1;
			end
			// registered one early so it lines up with the final count
			slot_end <= (count == count_t'(alpha_pkg::SLOT_CYCLES - 2));
		end
	end

	// undisturbed slots keep a fixed period
	slot_period : assert property (
		@(posedge clock) disable iff (reset)
		(slot_end && !restart) ##1 (!restart [*alpha_pkg::SLOT_CYCLES-1]) |=> slot_end
	);

endmodule

// File: design/startup_sequencer.sv
`timescale 1ns/1ps

// timed power-up sequence: dreset, sync, token, trigger, long gap, second token
module startup_sequencer (
	input logic clock,
	input logic reset,
	input logic start_pulse,
	output logic dreset,
	output logic sync,
	output logic tok_a_f2t,
	output logic trig_top
);

	typedef logic [$clog2(alpha_pkg::TRIGGER_GAP_SLOTS)-1:0] gap_t;

	alpha_pkg::startup_state_t state;
	gap_t gap_count; // slots spent in the gap so far
	logic slot_end;

	// slots are aligned to the start pulse
	slot_timer timer_i (
		.clock(clock),
		.reset(reset),
		.restart(start_pulse),
		.slot_end(slot_end)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= alpha_pkg::su_idle;
			gap_count <= '0;
			dreset <= 1'b0;
			sync <= 1'b0;
			tok_a_f2t <= 1'b0;
			trig_top <= 1'b0;
		end else if (start_pulse) begin // also aborts a running sequence
			state <= alpha_pkg::su_settle;
			gap_count <= '0;
			dreset <= 1'b0;
			sync <= 1'b0;
			tok_a_f2t <= 1'b0;
			trig_top <= 1'b0;
		end else if (slot_end) begin
			case (state)
				alpha_pkg::su_settle: begin
					state <= alpha_pkg::su_dreset_high;
					dreset <= 1'b1;
				end
				alpha_pkg::su_dreset_high: begin
					state <= alpha_pkg::su_dreset_low;
					dreset <= 1'b0;
				end
				alpha_pkg::su_dreset_low: begin
					state <= alpha_pkg::su_sync_high;
					sync <= 1'b1;
				end
				alpha_pkg::su_sync_high: begin
					state <= alpha_pkg::su_sync_low;
					sync <= 1'b0;
				end
				alpha_pkg::su_sync_low: begin
					state <= alpha_pkg::su_token_high;
					tok_a_f2t <= 1'b1; // first token
				end
				alpha_pkg::su_token_high: begin
					state <= alpha_pkg::su_token_low;
					tok_a_f2t <= 1'b0;
				end
				alpha_pkg::su_token_low: begin
					state <= alpha_pkg::su_trig_high;
					trig_top <= 1'b1;
				end
				alpha_pkg::su_trig_high: begin
					state <= alpha_pkg::su_trig_gap;
					trig_top <= 1'b0;
					gap_count <= '0;
				end
				alpha_pkg::su_trig_gap: begin
					if (gap_count == gap_t'(alpha_pkg::TRIGGER_GAP_SLOTS - 1)) begin
						state <= alpha_pkg::su_token2_high;
						tok_a_f2t <= 1'b1; // second token after the quiet stretch
					end else begin
						gap_count <= gap_count + 1'b1;
					end
				end
				alpha_pkg::su_token2_high: begin
					state <= alpha_pkg::su_token2_low;
					tok_a_f2t <= 1'b0;
				end
				default: state <= alpha_pkg::su_idle; // token2_low and idle end here
			endcase
		end
	end

	// phases never overlap on the board lines
	one_line_at_a_time : assert property (
		@(posedge clock) disable iff (reset)
		$onehot0({dreset, sync, tok_a_f2t, trig_top})
	);

endmodule

// File: sim/alpha_control_tb.sv
`timescale 1ns/1ps

// testbench for the carrier board start-up controller
module alpha_control_tb;

	// bit positions in the monitored line vector
	localparam int DRESET = 0;
	localparam int SYNC = 1;
	localparam int TOK = 2;
	localparam int TRIG = 3;
	localparam int SIN = 4;
	localparam int SCLK = 5;
	localparam int SLOT = alpha_pkg::SLOT_CYCLES;
	localparam int GAP_CYCLES = alpha_pkg::TRIGGER_GAP_SLOTS * SLOT;
	// 1131 slots per full power-up run
	localparam int SEQUENCE_CYCLES = (alpha_pkg::TRIGGER_GAP_SLOTS + 10) * SLOT;
	// one settle then three slots per load bit
	localparam int LOAD_CYCLES = (1 + 3 * alpha_pkg::LOAD_BITS) * SLOT;
	localparam int TIMEOUT_CYCLES = 2 * SEQUENCE_CYCLES + 2 * LOAD_CYCLES + 20000;

	logic clock;
	logic reset;
	logic [alpha_pkg::BUTTON_COUNT-1:0] button;
	logic dreset, sync, tok_a_f2t, trig_top, sin, sclk;
	logic [5:0] lines;
	logic [5:0] prev_lines;
	logic idle_window; // no button pressed yet
	int cycle;
	int fail_count;
	int tests_passed;
	int tests_failed;
	int rise_at[6][$]; // cycle of each rising step per line
	int fall_at[6][$];
	int sin_at_rise[$]; // sin seen on each sclk rise
	integer seed = 48537;

	alpha_control_top dut_i (
		.clock(clock),
		.reset(reset),
		.button(button),
		.dreset(dreset),
		.sync(sync),
		.tok_a_f2t(tok_a_f2t),
		.trig_top(trig_top),
		.sin(sin),
		.sclk(sclk)
	);

	assign lines = {sclk, sin, trig_top, tok_a_f2t, sync, dreset};

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// edge log for all the width and spacing checks
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (!reset) begin
			for (int i = 0; i < 6; i++) begin
				if (lines[i] && !prev_lines[i]) rise_at[i].push_back(cycle);
				if (!lines[i] && prev_lines[i]) fall_at[i].push_back(cycle);
			end
			if (lines[SCLK] && !prev_lines[SCLK]) sin_at_rise.push_back(int'(lines[SIN]));
		end
		prev_lines <= lines;
	end

	always @(posedge clock) begin
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	quiet_before_press : assert property (
		@(posedge clock) disable iff (!idle_window) lines == 6'b0
	) else begin
		$display("reset_state: an output went high with no button pressed");
		fail_count++;
	end

	dreset_forces_sclk : assert property (
		@(posedge clock) disable iff (reset) dreset |-> sclk
	) else begin
		$display("restart: sclk was low while dreset was high");
		fail_count++;
	end

	task check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("FAILED %s expected %0d actual %0d", name, expected, actual);
			fail_count++;
		end
	endtask

	task finish_test(input string name, input int errors_before);
		if (fail_count == errors_before) begin
			$display("%s: ok", name);
			tests_passed++;
		end else begin
			$display("%s: %0d errors", name, fail_count - errors_before);
			tests_failed++;
		end
	endtask

	task idle_cycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task press_button(input int index);
		@(posedge clock);
		button[index] <= 1'b1;
		repeat (12) @(posedge clock); // longer than the sample pipeline
		button[index] <= 1'b0;
	endtask

	task wait_for_fall(input int line, input int count);
		while (fall_at[line].size() < count) @(negedge clock);
	endtask

	// d picks the dreset/sync/trig pulse and t the first token of that run
	task check_power_up(input string name, input int d, input int t);
		check_value({name, " dreset width"}, SLOT, fall_at[DRESET][d] - rise_at[DRESET][d]);
		check_value({name, " sync delay"}, SLOT, rise_at[SYNC][d] - fall_at[DRESET][d]);
		check_value({name, " sync width"}, SLOT, fall_at[SYNC][d] - rise_at[SYNC][d]);
		check_value({name, " token delay"}, SLOT, rise_at[TOK][t] - fall_at[SYNC][d]);
		check_value({name, " token width"}, SLOT, fall_at[TOK][t] - rise_at[TOK][t]);
		check_value({name, " trig delay"}, SLOT, rise_at[TRIG][d] - fall_at[TOK][t]);
		check_value({name, " trig width"}, SLOT, fall_at[TRIG][d] - rise_at[TRIG][d]);
	endtask

	task check_second_token(input string name, input int d, input int t);
		check_value({name, " gap"}, GAP_CYCLES, rise_at[TOK][t+1] - fall_at[TRIG][d]);
		check_value({name, " width"}, SLOT, fall_at[TOK][t+1] - rise_at[TOK][t+1]);
	endtask

	initial begin
		int errors_before;
		int rise_base;
		int fall_base;
		reset <= 1'b1;
		button <= '0;
		idle_window <= 1'b0;
		fail_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		@(posedge clock);
		idle_window <= 1'b1; // outputs are registered from here on
		idle_cycles(3);
		reset <= 1'b0;

		errors_before = fail_count;
		idle_cycles(10 + $unsigned($random(seed)) % 20);
		idle_window <= 1'b0;
		@(negedge clock);
		finish_test("reset_state", errors_before);

		errors_before = fail_count;
		press_button(0);
		wait_for_fall(TRIG, 1);
		check_power_up("power_up", 0, 0);
		finish_test("power_up", errors_before);

		errors_before = fail_count;
		wait_for_fall(TOK, 2);
		check_second_token("second_token", 0, 0);
		idle_cycles(3 * SLOT); // nothing more should come
		check_value("second_token dreset count", 1, rise_at[DRESET].size());
		check_value("second_token sync count", 1, rise_at[SYNC].size());
		check_value("second_token token count", 2, rise_at[TOK].size());
		check_value("second_token trig count", 1, rise_at[TRIG].size());
		finish_test("second_token", errors_before);

		errors_before = fail_count;
		idle_cycles(5 + $unsigned($random(seed)) % 20);
		rise_base = rise_at[SCLK].size(); // earlier sclk pulse came from dreset
		fall_base = fall_at[SCLK].size();
		press_button(1);
		wait_for_fall(SCLK, fall_base + alpha_pkg::LOAD_BITS);
		idle_cycles(3 * SLOT);
		check_value("serial_load edges", alpha_pkg::LOAD_BITS, rise_at[SCLK].size() - rise_base);
		for (int k = 0; k < alpha_pkg::LOAD_BITS; k++) begin
			check_value($sformatf("serial_load sclk width %0d", k), SLOT,
				fall_at[SCLK][fall_base+k] - rise_at[SCLK][rise_base+k]);
			check_value($sformatf("serial_load sin %0d", k),
				int'(alpha_pkg::LOAD_WORD[k % $bits(alpha_pkg::LOAD_WORD)]),
				sin_at_rise[rise_base+k]); // dummy bits wrap to 0..3
		end
		finish_test("serial_load", errors_before);

		errors_before = fail_count;
		idle_cycles(5 + $unsigned($random(seed)) % 20);
		press_button(0);
		wait_for_fall(TRIG, 2);
		idle_cycles(50 * SLOT); // well inside the gap
		press_button(1); // load overlaps the new dreset pulse
		idle_cycles(150);
		press_button(0);
		wait_for_fall(TOK, 5);
		check_power_up("restart first run", 1, 2);
		check_power_up("restart", 2, 3);
		check_second_token("restart second token", 2, 3);
		check_value("restart dreset count", 3, rise_at[DRESET].size());
		finish_test("restart", errors_before);

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
